//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_ks_blwe
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
+incdir+.
ks_blwe_pkg.sv
ks_blram_ram.sv
ks_blram_core.sv
ks_rd_addr_cnt.sv
ks_rd_ctrl_fsm.sv
ks_blwe_top.sv
ks_blwe_sva.sv
tb_ks_blwe.sv

//--- ks_blram_core.sv
// --------------------------------------------------------------------------
// Batch LWE RAM core
// Write input pipe, read side-band tracking and output merge around the RAM
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ks_blwe_defs.svh"

module ks_blram_core #(
  parameter int RAM_LATENCY = `KS_RAM_LATENCY
) (
  input  logic                  clk,
  input  logic                  s_rst_n,
  // Host write
  input  logic                  wr_en,
  input  ks_blwe_pkg::wr_req_t  wr_req,
  // Read request from the counter
  input  logic                  rd_en,
  input  ks_blwe_pkg::rd_req_t  rd_req,
  // Read response, no back-pressure
  output logic                  rd_resp_avail,
  output ks_blwe_pkg::rd_resp_t rd_resp
);

  // --------------------------------------------------------------------------
  // Write input pipe
  // --------------------------------------------------------------------------
  logic                  s0_wr_en;
  ks_blwe_pkg::ram_add_t s0_wr_add;
  logic [`KS_OP_W-1:0]   s0_wr_data;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      s0_wr_en <= 1'b0;
    end else begin
      s0_wr_en <= wr_en;
    end
  end

  // Address mapped before the register
  always_ff @(posedge clk) begin
    s0_wr_add  <= ks_blwe_pkg::ram_add_f(wr_req.pos);
    s0_wr_data <= wr_req.data;
  end

  // --------------------------------------------------------------------------
  // Read side band, one stage per RAM latency cycle
  // --------------------------------------------------------------------------
  logic [RAM_LATENCY-1:0]                     sb_vld;
  ks_blwe_pkg::rd_req_t [RAM_LATENCY-1:0]     sb_req;
  logic [`KS_OP_W-1:0]                        ram_rd_data;

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sb_vld <= '0;
    end else begin
      sb_vld[0] <= rd_en;
      for (int i = 1; i < RAM_LATENCY; i++) begin
        sb_vld[i] <= sb_vld[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    sb_req[0] <= rd_req;
    for (int i = 1; i < RAM_LATENCY; i++) begin
      sb_req[i] <= sb_req[i-1];
    end
  end

  // Output register, side band joins RAM data here
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rd_resp_avail <= 1'b0;
    end else begin
      rd_resp_avail <= sb_vld[RAM_LATENCY-1];
    end
  end

  always_ff @(posedge clk) begin
    rd_resp.pos  <= sb_req[RAM_LATENCY-1].pos;
    rd_resp.last <= sb_req[RAM_LATENCY-1].last;
    rd_resp.data <= ram_rd_data;
  end

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------
  ks_blram_ram #(
    .WIDTH       (`KS_OP_W),
    .DEPTH       (`KS_RAM_DEPTH),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_ram (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_add  (ks_blwe_pkg::ram_add_f(rd_req.pos)),
    .rd_data (ram_rd_data),
    .wr_en   (s0_wr_en),
    .wr_add  (s0_wr_add),
    .wr_data (s0_wr_data)
  );

endmodule

//--- ks_blram_ram.sv
// --------------------------------------------------------------------------
// Behavioral 1R1W RAM
// Registered read followed by a delay line of RAM_LATENCY stages in total
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module ks_blram_ram #(
  parameter int WIDTH       = 32,
  parameter int DEPTH       = 32,
  parameter int RAM_LATENCY = 1
) (
  input  logic                     clk,
  // Read port
  input  logic                     rd_en,
  input  logic [$clog2(DEPTH)-1:0] rd_add,
  output logic [WIDTH-1:0]         rd_data,
  // Write port
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_add,
  input  logic [WIDTH-1:0]         wr_data
);

  logic [WIDTH-1:0] mem [DEPTH];
  // Stage 0 is the array read register
  logic [WIDTH-1:0] rd_pipe [RAM_LATENCY];

  // Write port, takes effect at the clock edge
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_add] <= wr_data;
    end
  end

  // Read same address as a write returns old content
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_add];
    end
    for (int i = 1; i < RAM_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data = rd_pipe[RAM_LATENCY-1];

endmodule

//--- ks_blwe_defs.svh
// --------------------------------------------------------------------------
// Batch LWE buffer sizing
// Operand width, batch and LWE dimensions, RAM read latency
// --------------------------------------------------------------------------
`ifndef KS_BLWE_DEFS_SVH
`define KS_BLWE_DEFS_SVH

// Width of one LWE coefficient
`define KS_OP_W 32

// Max PBS held in one batch
`define KS_BATCH_PBS_NB 4

// Coefficients per LWE
`define KS_LWE_K 8

// One word per (coefficient, PBS) pair
`define KS_RAM_DEPTH (`KS_BATCH_PBS_NB * `KS_LWE_K)

// RAM read latency, 1 or 2 only
`define KS_RAM_LATENCY 1

`endif

//--- ks_blwe_pkg.sv
// --------------------------------------------------------------------------
// Batch LWE buffer types
// Request and response structs, coefficient to RAM address mapping
// --------------------------------------------------------------------------
`include "ks_blwe_defs.svh"

package ks_blwe_pkg;

  localparam int RAM_ADD_W = $clog2(`KS_RAM_DEPTH);

  typedef logic [RAM_ADD_W-1:0] ram_add_t;
  typedef logic [1:0]           pbs_id_t;
  typedef logic [2:0]           coef_idx_t;
  // Legal range 1 to KS_BATCH_PBS_NB
  typedef logic [2:0]           pbs_nb_t;

  // Location of one coefficient in the batch
  typedef struct packed {
    pbs_id_t   pbs_id;
    coef_idx_t coef_idx;
  } coef_pos_t;

  typedef struct packed {
    coef_pos_t           pos;
    logic [`KS_OP_W-1:0] data;
  } wr_req_t;

  typedef struct packed {
    coef_pos_t pos;
    logic      last;
  } rd_req_t;

  typedef struct packed {
    coef_pos_t           pos;
    logic                last;
    logic [`KS_OP_W-1:0] data;
  } rd_resp_t;

  // Coefficient-major layout, PBS of one coefficient are adjacent
  function automatic ram_add_t ram_add_f(input coef_pos_t pos);
    return ram_add_t'(pos.coef_idx) * ram_add_t'(`KS_BATCH_PBS_NB)
           + ram_add_t'(pos.pbs_id);
  endfunction

endpackage

//--- ks_blwe_sva.sv
// --------------------------------------------------------------------------
// Batch LWE buffer protocol assertions
// Status and stream rules, bound to the top level
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module ks_blwe_sva (
  input logic clk,
  input logic s_rst_n,
  input logic busy,
  input logic done,
  input logic rd_resp_avail
);

  // done lands on the cycle busy drops
  a_done_after_busy: assert property (
    @(posedge clk) disable iff (!s_rst_n) done |-> $past(busy)
  ) else $error("done high without busy in the previous cycle");

  // Beats only leave during a batch
  a_avail_in_busy: assert property (
    @(posedge clk) disable iff (!s_rst_n) rd_resp_avail |-> busy
  ) else $error("rd_resp_avail high while not busy");

  // Single-cycle done strobe
  a_done_pulse: assert property (
    @(posedge clk) disable iff (!s_rst_n) done |=> !done
  ) else $error("done high on two consecutive cycles");

endmodule

bind ks_blwe_top ks_blwe_sva sva_i (
  .clk           (clk),
  .s_rst_n       (s_rst_n),
  .busy          (busy),
  .done          (done),
  .rd_resp_avail (rd_resp_avail)
);

//--- ks_blwe_top.sv
// --------------------------------------------------------------------------
// Batch LWE coefficient buffer
// Host loads one batch, a start streams it out coefficient-major
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ks_blwe_defs.svh"

module ks_blwe_top (
  input  logic                  clk,
  input  logic                  s_rst_n,
  // Host load
  input  logic                  wr_en,
  input  ks_blwe_pkg::wr_req_t  wr_req,
  // Batch start
  input  logic                  start,
  input  ks_blwe_pkg::pbs_nb_t  pbs_nb,
  // Coefficient stream
  output logic                  rd_resp_avail,
  output ks_blwe_pkg::rd_resp_t rd_resp,
  // Status
  output logic                  busy,
  output logic                  done
);

  logic                 cnt_clr;
  logic                 cnt_run;
  logic                 cnt_last;
  ks_blwe_pkg::pbs_nb_t cnt_pbs_nb;
  logic                 rd_en;
  ks_blwe_pkg::rd_req_t rd_req;

  ks_rd_ctrl_fsm u_fsm (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .start         (start),
    .pbs_nb        (pbs_nb),
    .cnt_last      (cnt_last),
    .rd_resp_avail (rd_resp_avail),
    .rd_resp       (rd_resp),
    .cnt_clr       (cnt_clr),
    .cnt_run       (cnt_run),
    .cnt_pbs_nb    (cnt_pbs_nb),
    .busy          (busy),
    .done          (done)
  );

  ks_rd_addr_cnt u_cnt (
    .clk      (clk),
    .s_rst_n  (s_rst_n),
    .cnt_clr  (cnt_clr),
    .cnt_run  (cnt_run),
    .pbs_nb   (cnt_pbs_nb),
    .rd_en    (rd_en),
    .rd_req   (rd_req),
    .cnt_last (cnt_last)
  );

  ks_blram_core #(
    .RAM_LATENCY (`KS_RAM_LATENCY)
  ) u_core (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .wr_en         (wr_en),
    .wr_req        (wr_req),
    .rd_en         (rd_en),
    .rd_req        (rd_req),
    .rd_resp_avail (rd_resp_avail),
    .rd_resp       (rd_resp)
  );

endmodule

//--- ks_rd_addr_cnt.sv
// --------------------------------------------------------------------------
// Batch read address counter
// PBS index inner, coefficient index outer, one read per cycle while running
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ks_blwe_defs.svh"

module ks_rd_addr_cnt (
  input  logic                 clk,
  input  logic                 s_rst_n,
  input  logic                 cnt_clr,
  input  logic                 cnt_run,
  input  ks_blwe_pkg::pbs_nb_t pbs_nb,
  output logic                 rd_en,
  output ks_blwe_pkg::rd_req_t rd_req,
  output logic                 cnt_last
);

  ks_blwe_pkg::pbs_nb_t   nb_q;
  ks_blwe_pkg::pbs_id_t   nxt_pbs;
  ks_blwe_pkg::coef_idx_t nxt_coef;
  logic                   pbs_wrap;
  logic                   nxt_last;

  // Batch size held for the whole run
  always_ff @(posedge clk) begin
    if (cnt_clr) begin
      nb_q <= pbs_nb;
    end
  end

  // Next position from the current request
  assign pbs_wrap = ks_blwe_pkg::pbs_nb_t'(rd_req.pos.pbs_id) == nb_q - 3'd1;
  assign nxt_pbs  = pbs_wrap ? '0 : rd_req.pos.pbs_id + 2'd1;
  assign nxt_coef = !pbs_wrap ? rd_req.pos.coef_idx
                  : (rd_req.pos.coef_idx == 3'(`KS_LWE_K - 1)) ? '0
                  : rd_req.pos.coef_idx + 3'd1;
  assign nxt_last = (nxt_coef == 3'(`KS_LWE_K - 1))
                  && (ks_blwe_pkg::pbs_nb_t'(nxt_pbs) == nb_q - 3'd1);

  // Request register doubles as the counter state
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rd_en  <= 1'b0;
      rd_req <= '0;
    end else if (cnt_clr) begin
      // Position 0 never ends a batch of several coefficients
      rd_en       <= 1'b1;
      rd_req.pos  <= '0;
      rd_req.last <= 1'b0;
    end else if (cnt_run && !rd_req.last) begin
      rd_en           <= 1'b1;
      rd_req.pos      <= '{pbs_id: nxt_pbs, coef_idx: nxt_coef};
      rd_req.last     <= nxt_last;
    end else begin
      rd_en <= 1'b0;
    end
  end

  // High on the cycle the final read goes out
  assign cnt_last = rd_en && rd_req.last;

endmodule

//--- ks_rd_ctrl_fsm.sv
// --------------------------------------------------------------------------
// Batch read control FSM
// Start, run, drain of the RAM pipe, then a done pulse
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ks_blwe_defs.svh"

module ks_rd_ctrl_fsm (
  input  logic                  clk,
  input  logic                  s_rst_n,
  input  logic                  start,
  input  ks_blwe_pkg::pbs_nb_t  pbs_nb,
  input  logic                  cnt_last,
  input  logic                  rd_resp_avail,
  input  ks_blwe_pkg::rd_resp_t rd_resp,
  output logic                  cnt_clr,
  output logic                  cnt_run,
  output ks_blwe_pkg::pbs_nb_t  cnt_pbs_nb,
  output logic                  busy,
  output logic                  done
);

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    RUN   = 2'd1,
    DRAIN = 2'd2
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   last_resp;

  assign last_resp = rd_resp_avail && rd_resp.last;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    if (start)     state_nxt = RUN;
      // Reads all issued, wait for the pipe to empty
      RUN:     if (cnt_last)  state_nxt = DRAIN;
      DRAIN:   if (last_resp) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      state <= IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_nxt;
      done  <= (state == DRAIN) && last_resp;
    end
  end

  // Start while busy is dropped here
  assign cnt_clr = (state == IDLE) && start;
  assign cnt_run = (state == RUN);
  assign busy    = (state != IDLE);

  // Out-of-range batch sizes clamped to 1 .. KS_BATCH_PBS_NB
  assign cnt_pbs_nb = (pbs_nb == '0) ? 3'd1
                    : (pbs_nb > 3'(`KS_BATCH_PBS_NB)) ? 3'(`KS_BATCH_PBS_NB)
                    : pbs_nb;

endmodule

//--- tb_ks_blwe.sv
// --------------------------------------------------------------------------
// Batch LWE buffer testbench
// Table of batch sizes against a RAM model, beat by beat compare, watchdog
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`include "ks_blwe_defs.svh"

module tb_ks_blwe;

  localparam int TBL_LEN   = 7;
  localparam int RST_CYC   = 2;
  // Cycle budget per table entry
  localparam int BATCH_CYC = 60;

  typedef struct packed {
    ks_blwe_pkg::pbs_nb_t pbs_nb;
    logic                 ign_start;
    logic                 one_write;
  } tbl_entry_t;

  logic                  clk;
  logic                  s_rst_n;
  logic                  wr_en;
  ks_blwe_pkg::wr_req_t  wr_req;
  logic                  start;
  ks_blwe_pkg::pbs_nb_t  pbs_nb;
  logic                  rd_resp_avail;
  ks_blwe_pkg::rd_resp_t rd_resp;
  logic                  busy;
  logic                  done;

  tbl_entry_t          tbl [TBL_LEN];
  // Expected RAM content, indexed by PBS then coefficient
  logic [`KS_OP_W-1:0] model [`KS_BATCH_PBS_NB][`KS_LWE_K];
  integer              seed;
  int                  err_cnt;
  int                  chk_cnt;

  ks_blwe_top dut_i (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .wr_en         (wr_en),
    .wr_req        (wr_req),
    .start         (start),
    .pbs_nb        (pbs_nb),
    .rd_resp_avail (rd_resp_avail),
    .rd_resp       (rd_resp),
    .busy          (busy),
    .done          (done)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  // Idle outputs, sampled mid-cycle
  task automatic check_quiet();
    @(negedge clk);
    check_val("busy", 32'd0, 32'(busy));
    check_val("done", 32'd0, 32'(done));
    check_val("rd_resp_avail", 32'd0, 32'(rd_resp_avail));
  endtask

  task automatic drive_write(input int pbs, input int coef, input logic [`KS_OP_W-1:0] data);
    @(posedge clk);
    #1;
    wr_en               = 1'b1;
    wr_req.pos.pbs_id   = 2'(pbs);
    wr_req.pos.coef_idx = 3'(coef);
    wr_req.data         = data;
    model[pbs][coef]    = data;
  endtask

  task automatic end_write();
    @(posedge clk);
    #1;
    wr_en = 1'b0;
    check_quiet();
  endtask

  task automatic load_batch(input int nb);
    for (int c = 0; c < `KS_LWE_K; c++) begin
      for (int p = 0; p < nb; p++) begin
        drive_write(p, c, $random(seed));
      end
    end
    end_write();
  endtask

  // One coefficient changed, all other beats must keep their old value
  task automatic rewrite_one(input int nb);
    int                  idx;
    logic [`KS_OP_W-1:0] data;
    idx  = {$random(seed)} % (`KS_LWE_K * nb);
    data = $random(seed);
    if (data == model[idx % nb][idx / nb]) begin
      data = ~data;
    end
    drive_write(idx % nb, idx / nb, data);
    end_write();
  endtask

  // Start at cycle 0, reads from 1, beats from 3, done right after last beat
  task automatic run_batch(input int nb, input logic ign);
    int cyc;
    int beats;
    int done_cnt;
    int done_cyc;
    int last_cyc;
    cyc      = 0;
    beats    = 0;
    done_cnt = 0;
    done_cyc = -1;
    last_cyc = 3 + `KS_LWE_K * nb;
    while ((done_cyc < 0 || cyc <= done_cyc + 2) && cyc < BATCH_CYC) begin
      @(posedge clk);
      #1;
      // Second strobe mid-run carries another size and must be dropped
      start  = (cyc == 0) || (ign && cyc == 4);
      pbs_nb = (cyc == 0) ? 3'(nb) : 3'(5 - nb);
      @(negedge clk);
      check_val("busy", 32'(cyc >= 1 && cyc < last_cyc), 32'(busy));
      check_val("done", 32'(cyc == last_cyc), 32'(done));
      check_val("rd_resp_avail", 32'(cyc >= 3 && cyc < last_cyc), 32'(rd_resp_avail));
      if (done) begin
        done_cnt++;
        if (done_cyc < 0) begin
          done_cyc = cyc;
        end
      end
      if (rd_resp_avail) begin
        check_val("rd_resp.pos.coef_idx", 32'(beats / nb), 32'(rd_resp.pos.coef_idx));
        check_val("rd_resp.pos.pbs_id", 32'(beats % nb), 32'(rd_resp.pos.pbs_id));
        check_val("rd_resp.last", 32'(beats == `KS_LWE_K * nb - 1), 32'(rd_resp.last));
        check_val("rd_resp.data", model[beats % nb][beats / nb], rd_resp.data);
        beats++;
      end
      cyc++;
    end
    start = 1'b0;
    if (done_cyc < 0) begin
      $display("no done pulse within %0d cycles of start, pbs_nb %0d", BATCH_CYC, nb);
    end
    check_val("beat count", 32'(`KS_LWE_K * nb), 32'(beats));
    check_val("done count", 32'd1, 32'(done_cnt));
  endtask

  initial begin
    int nb;
    seed    = 32'h22cd_7dae;
    err_cnt = 0;
    chk_cnt = 0;
    s_rst_n = 1'b0;
    wr_en   = 1'b0;
    wr_req  = '0;
    start   = 1'b0;
    pbs_nb  = 3'd1;
    // pbs_nb, start-while-busy, single rewrite only
    tbl[0] = '{3'd1, 1'b0, 1'b0};
    tbl[1] = '{3'd2, 1'b0, 1'b0};
    tbl[2] = '{3'd3, 1'b1, 1'b0};
    tbl[3] = '{3'd4, 1'b0, 1'b0};
    tbl[4] = '{3'd4, 1'b0, 1'b1};
    tbl[5] = '{3'd2, 1'b1, 1'b1};
    tbl[6] = '{3'd3, 1'b0, 1'b0};
    repeat (RST_CYC) @(posedge clk);
    #1;
    s_rst_n = 1'b1;
    repeat (3) check_quiet();
    for (int i = 0; i < TBL_LEN; i++) begin
      nb = int'(tbl[i].pbs_nb);
      if (tbl[i].one_write) begin
        rewrite_one(nb);
      end else begin
        load_batch(nb);
      end
      run_batch(nb, tbl[i].ign_start);
    end
    $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TBL_LEN * BATCH_CYC + RST_CYC) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish",
             TBL_LEN * BATCH_CYC + RST_CYC);
    $display("Simulation failed");
    $finish;
  end

endmodule
